// File: hw/cipher_out_pkg.sv
package cipher_out_pkg;

	// Byte and block geometry
	localparam int BYTE_BITS = 8;
	localparam int BLOCK_BYTES = 16;
	localparam int BLOCK_BITS = BLOCK_BYTES * BYTE_BITS;
	localparam int IDX_BITS = $clog2(BLOCK_BYTES);

	// Output FIFO entries
	localparam int FIFO_DEPTH = 16;

	// One ciphertext byte
	typedef logic [BYTE_BITS-1:0] byte_t;

	// One ciphertext block, byte k at bits 8k+7 down to 8k
	typedef logic [BLOCK_BITS-1:0] block_t;

	// Position of the next byte within a block
	typedef logic [IDX_BITS-1:0] byte_idx_t;

	// FIFO word, last marks the final byte of a block
	typedef struct packed {
		logic last;
		byte_t data;
	} fifo_entry_t;

	typedef enum logic {
		SER_IDLE,
		SER_SEND
	} ser_state_t;

endpackage

// File: hw/flex_fifo.sv
`timescale 1ns/1ns

module flex_fifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
) (
	input logic clk,
	input logic n_rst,
	input logic w_enable,
	input logic [WIDTH-1:0] w_data,
	input logic r_enable,
	output logic [WIDTH-1:0] r_data,
	output logic empty,
	output logic full
);

	typedef logic [$clog2(DEPTH)-1:0] ptr_t;
	typedef logic [$clog2(DEPTH+1)-1:0] count_t;

	logic [WIDTH-1:0] mem [DEPTH];
	ptr_t wr_ptr;
	ptr_t rd_ptr;
	count_t count;
	logic do_write;
	logic do_read;

	assign do_write = w_enable && !full;
	assign do_read = r_enable && !empty;

	assign empty = (count == count_t'(0));
	assign full = (count == count_t'(DEPTH));

	// Head entry falls through without a read cycle
	assign r_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_write) begin
			mem[wr_ptr] <= w_data;
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_write) begin
				// Wrap explicitly so depths other than powers of two work
				if (int'(wr_ptr) == DEPTH - 1) begin
					wr_ptr <= '0;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (do_read) begin
				if (int'(rd_ptr) == DEPTH - 1) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// Writer must respect back-pressure
	a_no_write_when_full: assert property (
		@(posedge clk) disable iff (!n_rst)
		!(w_enable && full)
	) else $error("flex_fifo: write attempted while full");

	// Reader must only pop valid entries
	a_no_read_when_empty: assert property (
		@(posedge clk) disable iff (!n_rst)
		!(r_enable && empty)
	) else $error("flex_fifo: read attempted while empty");

endmodule

// File: hw/block_capture.sv
`timescale 1ns/1ns

module block_capture (
	input logic clk,
	input logic n_rst,
	input cipher_out_pkg::block_t cipher_block,
	input logic block_valid,
	input logic take,
	output cipher_out_pkg::block_t slot_block,
	output logic slot_full,
	output logic overrun
);

	import cipher_out_pkg::*;

	block_t slot_q;
	logic slot_full_q;
	logic overrun_q;
	logic accept;
	logic drop;

	// A take frees the slot on the same edge, so a new block still fits
	assign accept = block_valid && (!slot_full_q || take);
	assign drop = block_valid && slot_full_q && !take;

	assign slot_block = slot_q;
	assign slot_full = slot_full_q;
	assign overrun = overrun_q;

	always_ff @(posedge clk) begin
		if (accept) begin
			slot_q <= cipher_block;
		end
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			slot_full_q <= 1'b0;
			overrun_q <= 1'b0;
		end else begin
			slot_full_q <= accept || (slot_full_q && !take);
			// One pulse per discarded block
			overrun_q <= drop;
		end
	end

	// Serializer only takes a block that is actually waiting
	a_take_needs_block: assert property (
		@(posedge clk) disable iff (!n_rst)
		take |-> slot_full_q
	) else $error("block_capture: take while slot empty");

endmodule

// File: hw/block_serializer.sv
`timescale 1ns/1ns

module block_serializer (
	input logic clk,
	input logic n_rst,
	input cipher_out_pkg::block_t slot_block,
	input logic slot_full,
	input logic full,
	output logic take,
	output logic w_enable,
	output cipher_out_pkg::fifo_entry_t w_data
);

	import cipher_out_pkg::*;

	ser_state_t state;
	ser_state_t next_state;
	block_t shift_q;
	byte_idx_t idx_q;
	logic last_byte;

	// Grab a waiting block whenever idle
	assign take = (state == SER_IDLE) && slot_full;

	// Full is the only back-pressure
	assign w_enable = (state == SER_SEND) && !full;

	assign last_byte = (idx_q == byte_idx_t'(BLOCK_BYTES - 1));

	// Low byte of the shift register is always the next one out
	assign w_data.last = last_byte;
	assign w_data.data = shift_q[BYTE_BITS-1:0];

	always_comb begin
		next_state = state;
		case (state)
			SER_IDLE: begin
				if (slot_full) begin
					next_state = SER_SEND;
				end
			end
			SER_SEND: begin
				if (w_enable && last_byte) begin
					next_state = SER_IDLE;
				end
			end
			default: begin
				next_state = SER_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state <= SER_IDLE;
			idx_q <= '0;
		end else begin
			state <= next_state;
			if (take) begin
				idx_q <= '0;
			end else if (w_enable) begin
				idx_q <= idx_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			shift_q <= slot_block;
		end else if (w_enable) begin
			shift_q <= shift_q >> BYTE_BITS;
		end
	end

	// Writes only happen mid-block
	a_write_in_send: assert property (
		@(posedge clk) disable iff (!n_rst)
		w_enable |-> (state == SER_SEND)
	) else $error("block_serializer: write outside SER_SEND");

endmodule

// File: hw/encrypted_fifo.sv
`timescale 1ns/1ns

module encrypted_fifo (
	input logic clk,
	input logic n_rst,
	input cipher_out_pkg::block_t cipher_block,
	input logic block_valid,
	input logic r_enable,
	output cipher_out_pkg::byte_t r_data,
	output logic r_last,
	output logic empty,
	output logic full,
	output logic overrun
);

	import cipher_out_pkg::*;

	block_t slot_block;
	logic slot_full;
	logic take;
	logic w_enable;
	fifo_entry_t w_data;
	fifo_entry_t head;

	// Holds the next block while the previous one drains
	block_capture capture0 (
		.clk(clk),
		.n_rst(n_rst),
		.cipher_block(cipher_block),
		.block_valid(block_valid),
		.take(take),
		.slot_block(slot_block),
		.slot_full(slot_full),
		.overrun(overrun)
	);

	block_serializer ser0 (
		.clk(clk),
		.n_rst(n_rst),
		.slot_block(slot_block),
		.slot_full(slot_full),
		.full(full),
		.take(take),
		.w_enable(w_enable),
		.w_data(w_data)
	);

	flex_fifo #(
		.WIDTH($bits(fifo_entry_t)),
		.DEPTH(FIFO_DEPTH)
	) fifo0 (
		.clk(clk),
		.n_rst(n_rst),
		.w_enable(w_enable),
		.w_data(w_data),
		.r_enable(r_enable),
		.r_data(head),
		.empty(empty),
		.full(full)
	);

	// Head entry split for the consumer
	assign r_data = head.data;
	assign r_last = head.last;

endmodule

// File: tests/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Expected FIFO contents, oldest byte at the front
fifo_entry_t model_q[$];

function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// Byte 0 leaves first, only byte 15 is tagged last
task automatic model_push_block(input block_t b);
	fifo_entry_t e;
	for (int k = 0; k < BLOCK_BYTES; k++) begin
		e.data = b[8*k +: 8];
		e.last = (k == BLOCK_BYTES - 1);
		model_q.push_back(e);
	end
endtask

task automatic model_pop(output fifo_entry_t e);
	if (model_q.size() == 0) begin
		$display("FAILED at %0t: DUT delivered a byte the model does not hold", $time);
		abort_run();
	end else begin
		e = model_q.pop_front();
	end
endtask

task automatic check_byte(input string what, input byte_t got, input byte_t exp);
	if (got !== exp) begin
		$display("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp);
		abort_run();
	end
endtask

task automatic check_last(input string what, input logic got, input logic exp);
	if (got !== exp) begin
		$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
		abort_run();
	end
endtask

// Status levels and pulses
task automatic check_flag(input string what, input logic got, input logic exp);
	if (got !== exp) begin
		$display("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
		abort_run();
	end
endtask

`endif

// File: tests/tb_encrypted_fifo.sv
`timescale 1ns/1ns

module tb_encrypted_fifo;

	import cipher_out_pkg::*;

	localparam int STREAM_BLOCKS = 200;
	localparam int HOLD_SPACING = 20;

	logic clk;
	logic n_rst;
	block_t cipher_block;
	logic block_valid;
	logic r_enable;
	byte_t r_data;
	logic r_last;
	logic empty;
	logic full;
	logic overrun;

	// Outputs as seen at the falling edge
	logic s_empty;
	logic s_full;
	logic s_overrun;
	byte_t s_data;
	logic s_last;

	logic [31:0] rng;
	logic reads_on;
	logic watch_overrun;
	logic send_req;
	block_t send_blk;
	int sent_bytes;
	int read_bytes;

	encrypted_fifo dut0 (
		.clk(clk),
		.n_rst(n_rst),
		.cipher_block(cipher_block),
		.block_valid(block_valid),
		.r_enable(r_enable),
		.r_data(r_data),
		.r_last(r_last),
		.empty(empty),
		.full(full),
		.overrun(overrun)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	task automatic abort_run();
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	`include "tb_model.svh"

	task automatic report_timeout(input string what, input int limit);
		$display("Timeout: %s did not happen within %0d cycles", what, limit);
		abort_run();
	endtask

	task automatic rand_word(output logic [31:0] w);
		rng = xorshift32(rng);
		w = rng;
	endtask

	task automatic rand_block(output block_t b);
		logic [31:0] w;
		for (int i = 0; i < 4; i++) begin
			rand_word(w);
			b[32*i +: 32] = w;
		end
	endtask

	// One clock: sample at the falling edge, pop and drive at the rising edge
	task automatic step_cycle();
		fifo_entry_t exp;
		logic [31:0] w;
		block_t junk;
		@(negedge clk);
		s_empty = empty;
		s_full = full;
		s_overrun = overrun;
		s_data = r_data;
		s_last = r_last;
		if (watch_overrun) begin
			check_flag("overrun", s_overrun, 1'b0);
		end
		if (sent_bytes == read_bytes) begin
			check_flag("empty with nothing outstanding", s_empty, 1'b1);
		end
		@(posedge clk);
		if (r_enable) begin
			model_pop(exp);
			check_byte("r_data", s_data, exp.data);
			check_last("r_last", s_last, exp.last);
			read_bytes++;
		end
		rand_word(w);
		// No pop at this edge, so the FIFO still holds a byte at the next one
		if (reads_on && !s_empty && !r_enable) begin
			r_enable <= (w[1:0] != 2'b00);
		end else begin
			r_enable <= 1'b0;
		end
		if (send_req) begin
			block_valid <= 1'b1;
			cipher_block <= send_blk;
			send_req = 1'b0;
		end else begin
			// Bus noise without a strobe
			rand_block(junk);
			block_valid <= 1'b0;
			cipher_block <= junk;
		end
	endtask

	task automatic send_block(input block_t b, input logic kept);
		send_req = 1'b1;
		send_blk = b;
		if (kept) begin
			model_push_block(b);
			sent_bytes += BLOCK_BYTES;
		end
		step_cycle();
	endtask

	task automatic drain(input int limit, input string what);
		int n;
		n = 0;
		while (read_bytes != sent_bytes) begin
			if (n >= limit) begin
				report_timeout(what, limit);
			end
			step_cycle();
			n++;
		end
	endtask

	task automatic wait_for_overrun(input int limit);
		int n;
		n = 0;
		step_cycle();
		while (!s_overrun) begin
			if (n >= limit) begin
				report_timeout("overrun pulse", limit);
			end
			step_cycle();
			n++;
		end
	endtask

	// FIFO, shift register and slot each end up with one block
	task automatic hold_three_blocks();
		block_t b;
		for (int i = 0; i < 3; i++) begin
			rand_block(b);
			send_block(b, 1'b1);
			repeat (HOLD_SPACING - 1) begin
				step_cycle();
			end
		end
		check_flag("full with three blocks held", s_full, 1'b1);
	endtask

	initial begin
		block_t b;
		logic [31:0] w;
		int blocks;
		int gap;
		int n;
		n_rst <= 1'b0;
		cipher_block <= '0;
		block_valid <= 1'b0;
		r_enable <= 1'b0;
		rng = 32'h53f4436c;
		reads_on = 1'b0;
		watch_overrun = 1'b1;
		send_req = 1'b0;
		send_blk = '0;
		sent_bytes = 0;
		read_bytes = 0;
		repeat (10) @(posedge clk);
		n_rst <= 1'b1;

		step_cycle();
		check_flag("empty after reset", s_empty, 1'b1);
		check_flag("full after reset", s_full, 1'b0);
		check_flag("overrun after reset", s_overrun, 1'b0);

		// Single block read back in byte order
		reads_on = 1'b1;
		rand_block(b);
		send_block(b, 1'b1);
		drain(100, "single block readback");

		// Random gaps and random reads
		blocks = 0;
		gap = 0;
		n = 0;
		while (blocks < STREAM_BLOCKS) begin
			if (n >= 40000) begin
				report_timeout("streaming of all blocks", 40000);
			end
			n++;
			if (gap == 0 && sent_bytes - read_bytes < BLOCK_BYTES + 1) begin
				rand_block(b);
				send_block(b, 1'b1);
				rand_word(w);
				gap = int'(w[2:0]);
				blocks++;
			end else begin
				if (gap > 0) begin
					gap--;
				end
				step_cycle();
			end
		end
		drain(2000, "streaming drain");

		// Back-pressure with reads stopped
		reads_on = 1'b0;
		hold_three_blocks();
		reads_on = 1'b1;
		drain(500, "back-pressure drain");

		// Fourth block has nowhere to go
		reads_on = 1'b0;
		hold_three_blocks();
		rand_block(b);
		watch_overrun = 1'b0;
		send_block(b, 1'b0);
		wait_for_overrun(10);
		watch_overrun = 1'b1;
		reads_on = 1'b1;
		drain(500, "overrun drain");
		step_cycle();
		check_flag("empty after overrun drain", s_empty, 1'b1);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// File: verilog.f
+incdir+tests
hw/cipher_out_pkg.sv
hw/flex_fifo.sv
hw/block_capture.sv
hw/block_serializer.sv
hw/encrypted_fifo.sv
tests/tb_encrypted_fifo.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	--top-module tb_encrypted_fifo \
	-f verilog.f \
	-o sim_tb

# The log is searched below, so a nonzero exit is not fatal here
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
